//--- source/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// register bus addresses
`define DMA_REG_ADDR  16'hFF46
`define HDMA1_ADDR    16'hFF51
`define HDMA2_ADDR    16'hFF52
`define HDMA3_ADDR    16'hFF53
`define HDMA4_ADDR    16'hFF54
`define HDMA5_ADDR    16'hFF55

// sprite table placement
`define OAM_BASE_HIGH 8'hFE
`define OAM_LENGTH    160

// general DMA destination window and block size
`define VRAM_PREFIX   3'b100
`define BLOCK_BYTES   16

`endif

//--- source/dma_pkg.sv
`default_nettype none

package dma_pkg;

   typedef logic [15:0] addr_t;   // memory or register address
   typedef logic [7:0]  data_t;
   typedef logic [11:0] count_t;  // up to 2048 beats

   typedef enum logic {
      OAM,
      GENERAL
   } dma_kind_e;

   typedef struct packed {
      addr_t     src_base;
      addr_t     dst_base;
      count_t    length;   // beats
      dma_kind_e kind;
   } xfer_desc_t;

   typedef struct packed {
      logic   busy;
      count_t remaining;   // beats not yet issued
   } dma_status_t;

endpackage

`default_nettype wire

//--- source/dma_if.sv
`timescale 1ns/1ps
`default_nettype none

// descriptor handoff from the register stage to the sequencer
interface dma_desc_if import dma_pkg::*; ();

   logic        valid;
   logic        ready;    // high while sequencer idle
   xfer_desc_t  desc;
   dma_status_t status;   // live transfer state for readback

   modport source (
      output valid,
      output desc,
      input  ready,
      input  status
   );

   modport sink (
      input  valid,
      input  desc,
      output ready,
      output status
   );

endinterface

// one address beat per cycle, no back-pressure
interface dma_beat_if import dma_pkg::*; ();

   logic  valid;
   addr_t src_addr;
   addr_t dst_addr;
   logic  last;

   modport source (
      output valid,
      output src_addr,
      output dst_addr,
      output last
   );

   modport sink (
      input valid,
      input src_addr,
      input dst_addr,
      input last
   );

endinterface

`default_nettype wire

//--- source/dma_reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_settings.svh"

module dma_reg_file import dma_pkg::*; (
   input  logic  I_CLK,
   input  logic  I_SYNC_RESET,
   input  addr_t reg_addr,
   input  data_t reg_wdata,
   input  logic  reg_we,
   input  logic  reg_re,
   output data_t reg_rdata,
   dma_desc_if.source desc
);

   data_t      dma_reg;
   data_t      hdma1;
   data_t      hdma2;
   data_t      hdma3;
   data_t      hdma4;
   logic [6:0] gen_blocks;   // HDMA5 low bits, n
   logic       oam_pend;
   logic       gen_pend;
   logic       locked;       // descriptor on offer, waiting for accept
   xfer_desc_t lock_desc;
   xfer_desc_t oam_desc;
   xfer_desc_t gen_desc;
   xfer_desc_t live_desc;
   count_t     blocks_left;
   data_t      hdma5_rd;
   logic       accept;
   logic       wr_hdma5;

   assign accept   = desc.valid && desc.ready;
   assign wr_hdma5 = reg_we && (reg_addr == `HDMA5_ADDR) && !reg_wdata[7]; // hblank mode ignored

   assign oam_desc = '{src_base: {dma_reg, 8'h00},
                       dst_base: {`OAM_BASE_HIGH, 8'h00},
                       length:   count_t'(`OAM_LENGTH),
                       kind:     OAM};

   assign gen_desc = '{src_base: {hdma1, hdma2[7:4], 4'h0},
                       dst_base: {`VRAM_PREFIX, hdma3[4:0], hdma4[7:4], 4'h0},
                       length:   count_t'(`BLOCK_BYTES) * (count_t'(gen_blocks) + count_t'(1)),
                       kind:     GENERAL};

   assign live_desc  = oam_pend ? oam_desc : gen_desc;   // OAM has priority
   assign desc.valid = oam_pend | gen_pend;
   assign desc.desc  = locked ? lock_desc : live_desc;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         dma_reg    <= '0;
         hdma1      <= '0;
         hdma2      <= '0;
         hdma3      <= '0;
         hdma4      <= '0;
         gen_blocks <= '0;
         oam_pend   <= 1'b0;
         gen_pend   <= 1'b0;
         locked     <= 1'b0;
      end else begin
         locked <= desc.valid && !accept;
         if (accept && desc.desc.kind == OAM) oam_pend <= 1'b0;
         if (accept && desc.desc.kind == GENERAL) gen_pend <= 1'b0;
         if (reg_we) begin
            case (reg_addr)
               `DMA_REG_ADDR: begin
                  dma_reg  <= reg_wdata;
                  oam_pend <= 1'b1;   // new write wins over the clear
               end
               `HDMA1_ADDR: hdma1 <= reg_wdata;
               `HDMA2_ADDR: hdma2 <= reg_wdata;
               `HDMA3_ADDR: hdma3 <= reg_wdata;
               `HDMA4_ADDR: hdma4 <= reg_wdata;
               default: ;
            endcase
         end
         if (wr_hdma5) begin
            gen_blocks <= reg_wdata[6:0];
            gen_pend   <= 1'b1;
         end
      end
   end

   // hold the offered descriptor steady until it is taken
   always_ff @(posedge I_CLK) begin
      lock_desc <= desc.desc;
   end

   // round up so a partly sent block still counts
   assign blocks_left = (desc.status.remaining + count_t'(`BLOCK_BYTES - 1)) /
                        count_t'(`BLOCK_BYTES);
   assign hdma5_rd    = desc.status.busy ? {1'b0, blocks_left[6:0] - 7'd1} : 8'hFF;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         reg_rdata <= '0;
      end else if (reg_re) begin
         case (reg_addr)
            `DMA_REG_ADDR: reg_rdata <= dma_reg;
            `HDMA1_ADDR:   reg_rdata <= hdma1;
            `HDMA2_ADDR:   reg_rdata <= hdma2;
            `HDMA3_ADDR:   reg_rdata <= hdma3;
            `HDMA4_ADDR:   reg_rdata <= hdma4;
            `HDMA5_ADDR:   reg_rdata <= hdma5_rd;
            default:       reg_rdata <= 8'h00;
         endcase
      end
   end

   // an offered descriptor stays up and unchanged until the sequencer takes it
   a_desc_held : assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      desc.valid && !desc.ready |=> desc.valid && $stable(desc.desc));

endmodule

`default_nettype wire

//--- source/dma_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_settings.svh"

module dma_sequencer import dma_pkg::*; (
   input  logic I_CLK,
   input  logic I_SYNC_RESET,
   dma_desc_if.sink   desc,
   dma_beat_if.source beat,
   output logic busy
);

   typedef enum logic {
      IDLE,
      XFER
   } seq_state_e;

   seq_state_e state;
   xfer_desc_t desc_q;   // latched on accept
   count_t     count;    // beats issued so far
   logic       accept;
   logic       emit;

   assign accept      = desc.valid && desc.ready;
   assign desc.ready  = (state == IDLE);
   assign busy        = (state == XFER);
   assign desc.status = {busy, count_t'(desc_q.length - count)};
   assign emit        = (state == XFER) && !beat.last;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         state      <= IDLE;
         desc_q     <= '0;
         count      <= '0;
         beat.valid <= 1'b0;
         beat.last  <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (accept) begin
                  state  <= XFER;
                  desc_q <= desc.desc;
                  count  <= '0;
               end
            end
            XFER: begin
               if (beat.last) begin   // final beat just presented
                  state      <= IDLE;
                  beat.valid <= 1'b0;
                  beat.last  <= 1'b0;
               end else begin
                  beat.valid <= 1'b1;
                  beat.last  <= (count == desc_q.length - count_t'(1));
                  count      <= count + count_t'(1);
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge I_CLK) begin
      if (emit) begin
         beat.src_addr <= desc_q.src_base + addr_t'(count);
         beat.dst_addr <= desc_q.dst_base + addr_t'(count);
      end
   end

   a_no_beat_in_idle : assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      state == IDLE |-> !beat.valid);

endmodule

`default_nettype wire

//--- source/dma_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module dma_mem_port import dma_pkg::*; (
   input  logic  I_CLK,
   input  logic  I_SYNC_RESET,
   dma_beat_if.sink beat,
   output addr_t rd_addr,
   output logic  rd_en,
   input  data_t rd_data,
   output addr_t wr_addr,
   output data_t wr_data,
   output logic  wr_en,
   output logic  pending
);

   addr_t rd_dst;         // destination riding with the read
   addr_t wait_dst;       // read data due next cycle
   logic  wait_valid;

   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         rd_en      <= 1'b0;
         wait_valid <= 1'b0;
         wr_en      <= 1'b0;
      end else begin
         rd_en      <= beat.valid;
         wait_valid <= rd_en;   // memory samples the read here
         wr_en      <= wait_valid;
      end
   end

   always_ff @(posedge I_CLK) begin
      rd_addr  <= beat.src_addr;
      rd_dst   <= beat.dst_addr;
      wait_dst <= rd_dst;
      wr_addr  <= wait_dst;
      wr_data  <= rd_data;   // one-cycle synchronous read result
   end

   // beats not yet at the write stage
   assign pending = rd_en | wait_valid;

   a_write_after_read : assert property (@(posedge I_CLK) disable iff (I_SYNC_RESET)
      wr_en |-> $past(rd_en, 2));

endmodule

`default_nettype wire

//--- source/dma_controller.sv
`timescale 1ns/1ps
`default_nettype none

module dma_controller import dma_pkg::*; (
   input  logic  I_CLK,
   input  logic  I_SYNC_RESET,

   // register bus
   input  addr_t reg_addr,
   input  data_t reg_wdata,
   input  logic  reg_we,
   input  logic  reg_re,
   output data_t reg_rdata,

   // memory side
   output addr_t rd_addr,
   output logic  rd_en,
   input  data_t rd_data,
   output addr_t wr_addr,
   output data_t wr_data,
   output logic  wr_en,

   output logic  halt_cpu
);

   dma_desc_if desc_if ();
   dma_beat_if beat_if ();

   logic seq_busy;
   logic port_pending;

   dma_reg_file reg_file_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_we       (reg_we),
      .reg_re       (reg_re),
      .reg_rdata    (reg_rdata),
      .desc         (desc_if.source)
   );

   dma_sequencer sequencer_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .desc         (desc_if.sink),
      .beat         (beat_if.source),
      .busy         (seq_busy)
   );

   dma_mem_port mem_port_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .beat         (beat_if.sink),
      .rd_addr      (rd_addr),
      .rd_en        (rd_en),
      .rd_data      (rd_data),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .wr_en        (wr_en),
      .pending      (port_pending)
   );

   // CPU stays stopped from the first beat through the last write
   always_ff @(posedge I_CLK) begin
      if (I_SYNC_RESET) begin
         halt_cpu <= 1'b0;
      end else begin
         halt_cpu <= seq_busy | port_pending;
      end
   end

endmodule

`default_nettype wire

//--- verif/dma_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "dma_settings.svh"

module dma_controller_tb import dma_pkg::*; ();

   localparam logic [31:0] SEED = 32'h68bea40c;
   localparam int N_ENTRIES = 5;

   typedef struct packed {
      dma_kind_e kind;
      logic      wait_done;            // drain and check before the next entry
      data_t     v1, v2, v3, v4, v5;   // DMA reg or HDMA1..HDMA5 values
      addr_t     src;
      addr_t     dst;
      count_t    len;
   } entry_t;

   logic  I_CLK;
   logic  I_SYNC_RESET;
   addr_t reg_addr;
   data_t reg_wdata;
   logic  reg_we;
   logic  reg_re;
   data_t reg_rdata;
   addr_t rd_addr;
   logic  rd_en;
   data_t rd_data;
   addr_t wr_addr;
   data_t wr_data;
   logic  wr_en;
   logic  halt_cpu;

   entry_t stim [N_ENTRIES];
   addr_t  exp_addr[$];
   data_t  exp_data[$];
   addr_t  got_addr[$];
   data_t  got_data[$];

   dma_controller dut_i (
      .I_CLK        (I_CLK),
      .I_SYNC_RESET (I_SYNC_RESET),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_we       (reg_we),
      .reg_re       (reg_re),
      .reg_rdata    (reg_rdata),
      .rd_addr      (rd_addr),
      .rd_en        (rd_en),
      .rd_data      (rd_data),
      .wr_addr      (wr_addr),
      .wr_data      (wr_data),
      .wr_en        (wr_en),
      .halt_cpu     (halt_cpu)
   );

   initial begin
      I_CLK = 1'b0;
      forever #5 I_CLK = ~I_CLK;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic data_t pattern(input addr_t a);
      logic [31:0] x;
      x = xorshift(SEED ^ {16'h0000, a});
      return x[31:24] ^ x[23:16] ^ x[15:8] ^ x[7:0];   // fold all bytes
   endfunction

   // synchronous memory, data one cycle after rd_en
   always @(posedge I_CLK) begin
      if (rd_en) rd_data <= pattern(rd_addr);
   end

   always @(negedge I_CLK) begin
      if (wr_en) begin
         got_addr.push_back(wr_addr);
         got_data.push_back(wr_data);
      end
      if ((rd_en || wr_en) && !halt_cpu) begin
         $display("halt_cpu is low while the DMA uses the memory bus");
         abort_run();
      end
   end

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic tick();
      @(posedge I_CLK);
      #1;   // drive and sample past the edge
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_status(input string name, input dma_status_t got,
                               input dma_status_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic reg_write(input addr_t a, input data_t d);
      reg_addr  = a;
      reg_wdata = d;
      reg_we    = 1'b1;
      tick();
      reg_we    = 1'b0;
   endtask

   task automatic reg_read(input addr_t a, output data_t v);
      reg_addr = a;
      reg_re   = 1'b1;
      tick();
      reg_re   = 1'b0;
      v        = reg_rdata;   // registered read, valid one cycle later
   endtask

   task automatic expect_reg(input string name, input addr_t a, input data_t exp);
      data_t v;
      reg_read(a, v);
      check_data(name, v, exp);
   endtask

   task automatic wait_halt();
      int cycles;
      cycles = 0;
      while (!halt_cpu) begin
         tick();
         cycles++;
         if (cycles > 20) begin
            $display("timeout waiting for halt_cpu to rise");
            abort_run();
         end
      end
   endtask

   task automatic drain_writes();
      int cycles;
      cycles = 0;
      while (got_addr.size() < exp_addr.size()) begin
         tick();
         cycles++;
         if (cycles > 5000) begin
            $display("timeout waiting for the DMA writes to finish");
            abort_run();
         end
      end
      repeat (2) tick();
      if (got_addr.size() != exp_addr.size()) begin
         $display("the DMA made more writes than expected");
         abort_run();
      end
      if (halt_cpu) begin
         $display("halt_cpu is still high after the last write");
         abort_run();
      end
      foreach (exp_addr[i]) begin
         check_addr("wr_addr", got_addr[i], exp_addr[i]);
         check_data("wr_data", got_data[i], exp_data[i]);
      end
      exp_addr.delete();
      exp_data.delete();
      got_addr.delete();
      got_data.delete();
   endtask

   task automatic run_entry(input entry_t e);
      data_t v;
      if (e.kind == OAM) begin
         reg_write(`DMA_REG_ADDR, e.v1);
      end else begin
         reg_write(`HDMA1_ADDR, e.v1);
         reg_write(`HDMA2_ADDR, e.v2);
         reg_write(`HDMA3_ADDR, e.v3);
         reg_write(`HDMA4_ADDR, e.v4);
         reg_write(`HDMA5_ADDR, e.v5);
      end
      for (int i = 0; i < int'(e.len); i++) begin
         exp_addr.push_back(e.dst + addr_t'(i));
         exp_data.push_back(pattern(e.src + addr_t'(i)));
      end
      if (e.wait_done) begin
         if (e.kind == GENERAL) begin
            wait_halt();
            reg_read(`HDMA5_ADDR, v);
            check_data("hdma5 bit 7 while busy", {7'h00, v[7]}, 8'h00);
         end
         drain_writes();
         expect_reg("hdma5 after transfer", `HDMA5_ADDR, 8'hFF);
         if (e.kind == OAM) begin
            expect_reg("dma_reg", `DMA_REG_ADDR, e.v1);
         end else begin
            expect_reg("hdma1", `HDMA1_ADDR, e.v1);
            expect_reg("hdma2", `HDMA2_ADDR, e.v2);
            expect_reg("hdma3", `HDMA3_ADDR, e.v3);
            expect_reg("hdma4", `HDMA4_ADDR, e.v4);
         end
      end
   endtask

   initial begin
      dma_status_t idle_st;
      idle_st      = '0;
      I_SYNC_RESET = 1'b1;
      reg_addr     = '0;
      reg_wdata    = '0;
      reg_we       = 1'b0;
      reg_re       = 1'b0;
      rd_data      = '0;
      stim[0] = '{OAM, 1'b1, 8'hC1, 8'h00, 8'h00, 8'h00, 8'h00, 16'hC100, 16'hFE00, 12'd160};
      stim[1] = '{GENERAL, 1'b1, 8'h12, 8'h3F, 8'hE5, 8'hA7, 8'h02, 16'h1230, 16'h85A0, 12'd48};
      stim[2] = '{GENERAL, 1'b1, 8'h40, 8'h08, 8'h01, 8'hFF, 8'h00, 16'h4000, 16'h81F0, 12'd16};
      stim[3] = '{OAM, 1'b0, 8'h05, 8'h00, 8'h00, 8'h00, 8'h00, 16'h0500, 16'hFE00, 12'd160};
      stim[4] = '{GENERAL, 1'b1, 8'h9A, 8'hFF, 8'h1F, 8'h00, 8'h01, 16'h9AF0, 16'h9F00, 12'd32};
      repeat (2) tick();
      I_SYNC_RESET = 1'b0;

      expect_reg("dma_reg", `DMA_REG_ADDR, 8'h00);
      expect_reg("hdma1", `HDMA1_ADDR, 8'h00);
      expect_reg("hdma2", `HDMA2_ADDR, 8'h00);
      expect_reg("hdma3", `HDMA3_ADDR, 8'h00);
      expect_reg("hdma4", `HDMA4_ADDR, 8'h00);
      expect_reg("hdma5 idle", `HDMA5_ADDR, 8'hFF);
      check_status("status", dut_i.desc_if.status, idle_st);

      // entry 4 is queued behind the OAM copy of entry 3
      for (int i = 0; i < N_ENTRIES; i++) begin
         run_entry(stim[i]);
      end

      reg_write(`HDMA5_ADDR, 8'h83);   // hblank mode, must be ignored
      repeat (30) begin
         tick();
         if (rd_en || wr_en) begin
            $display("a HDMA5 write with bit 7 set started a transfer");
            abort_run();
         end
      end
      check_status("status", dut_i.desc_if.status, idle_st);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- dma_controller.f
+incdir+source
source/dma_pkg.sv
source/dma_if.sv
source/dma_reg_file.sv
source/dma_sequencer.sv
source/dma_mem_port.sv
source/dma_controller.sv
verif/dma_controller_tb.sv

//--- Bender.yml
package:
  name: dma_controller

sources:
  - include_dirs:
      - source
    files:
      - source/dma_pkg.sv
      - source/dma_if.sv
      - source/dma_reg_file.sv
      - source/dma_sequencer.sv
      - source/dma_mem_port.sv
      - source/dma_controller.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/dma_controller_tb.sv
